// ==== compile.f ====
+incdir+source
source/afifo_pkg.sv
source/gray_ptr_sync.sv
source/wr_ctrl.sv
source/rd_ctrl.sv
source/word_ram.sv
source/width_down_fifo.sv
tb/tb_width_down_fifo.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
# builds and runs the testbench with Verilator
set -e
set -o pipefail

cd "$(dirname "$0")"

rm -rf obj_dir sim.log

verilator --binary --timing --assert -Wno-fatal \
    -f compile.f \
    --top-module tb_width_down_fifo \
    -o sim_tb_width_down_fifo

./obj_dir/sim_tb_width_down_fifo 2>&1 | tee sim.log

if grep -q "^Test OK$" sim.log; then
    echo "simulation passed"
    exit 0
else
    echo "simulation failed, see sim.log"
    exit 1
fi

// ==== source/afifo_consts.svh ====
`ifndef AFIFO_CONSTS_SVH
`define AFIFO_CONSTS_SVH

// write side word
`define AFIFO_WORD_W        32

// read side item
`define AFIFO_LANE_W        8

// items per word, read msb lane first
`define AFIFO_LANES         (`AFIFO_WORD_W / `AFIFO_LANE_W)

// log2 of lanes
`define AFIFO_LANE_SEL_W    2

// memory depth in full words
`define AFIFO_DEPTH         16

// log2 of depth, pointers carry one extra wrap bit
`define AFIFO_ADDR_W        4

`endif

// ==== source/afifo_pkg.sv ====
`include "afifo_consts.svh"

package afifo_pkg;

    // one write word, seen either whole or as lanes for the read mux
    typedef union packed {
        logic [`AFIFO_WORD_W-1:0]                    raw;
        logic [`AFIFO_LANES-1:0][`AFIFO_LANE_W-1:0]  lanes;   // [3] is read first
    } wr_word_u;

    // word pointer with wrap bit, binary or gray
    typedef logic [`AFIFO_ADDR_W:0] word_ptr_t;

    // item pointer with wrap bit
    // upper part is the word address, low bits pick the lane
    typedef logic [`AFIFO_ADDR_W+`AFIFO_LANE_SEL_W:0] item_ptr_t;

    // read output
    typedef struct packed {
        logic                     valid;
        logic [`AFIFO_LANE_W-1:0] data;
    } rd_beat_t;

endpackage

// ==== source/gray_ptr_sync.sv ====
`timescale 1ns/1ps
`include "afifo_consts.svh"

module gray_ptr_sync import afifo_pkg::*; (
    input  logic      clk,
    input  logic      rst,
    input  word_ptr_t gray_in,
    output word_ptr_t bin_out
);

    word_ptr_t gray_meta;   // first stage, may go metastable
    word_ptr_t gray_sync;   // settled copy in this domain

    // top bit copies through, each lower bit xors with the binary bit above
    function automatic word_ptr_t gray2bin(input word_ptr_t g);
        word_ptr_t b;
        b[`AFIFO_ADDR_W] = g[`AFIFO_ADDR_W];
        for (int i = `AFIFO_ADDR_W - 1; i >= 0; i--) begin
            b[i] = g[i] ^ b[i + 1];
        end
        return b;
    endfunction

    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            gray_meta <= '0;
            gray_sync <= '0;
        end else begin
            gray_meta <= gray_in;
            gray_sync <= gray_meta;
        end
    end

    assign bin_out = gray2bin(gray_sync);

    // source side must move at most one step per destination cycle
    a_one_bit_step: assert property (
        @(posedge clk) disable iff (!rst)
        $countones(gray_sync ^ $past(gray_sync)) <= 1
    ) else $error("gray pointer jumped more than one bit");

endmodule

// ==== source/rd_ctrl.sv ====
`timescale 1ns/1ps
`include "afifo_consts.svh"

module rd_ctrl import afifo_pkg::*; (
    input  logic      rd_clk,
    input  logic      rd_rst,
    input  logic      rd_en,
    input  word_ptr_t wr_ptr_sync,
    input  wr_word_u  ram_word,
    output word_ptr_t rd_addr,
    output word_ptr_t rd_addr_gray,
    output logic      ram_re,
    output logic      empty,
    output rd_beat_t  beat
);

    item_ptr_t                   item_ptr;
    item_ptr_t                   item_ptr_next;
    word_ptr_t                   rd_addr_next;
    logic [`AFIFO_LANE_SEL_W-1:0] lane_sel_q;   // lane of the word now in the ram output reg
    logic                        valid_q;

    // word address is the item pointer minus its lane bits
    assign rd_addr = item_ptr[`AFIFO_ADDR_W+`AFIFO_LANE_SEL_W:`AFIFO_LANE_SEL_W];

    // word stays occupied until its last lane is taken
    assign empty  = (rd_addr == wr_ptr_sync);
    assign ram_re = rd_en && !empty;   // accepted read

    assign item_ptr_next = item_ptr + 1'b1;
    assign rd_addr_next  =
        item_ptr_next[`AFIFO_ADDR_W+`AFIFO_LANE_SEL_W:`AFIFO_LANE_SEL_W];

    always_ff @(posedge rd_clk or negedge rd_rst) begin
        if (!rd_rst) begin
            item_ptr     <= '0;
            rd_addr_gray <= '0;
        end else if (ram_re) begin
            item_ptr     <= item_ptr_next;
            rd_addr_gray <= rd_addr_next ^ (rd_addr_next >> 1);
        end
    end

    // select and valid line up with the ram read register
    always_ff @(posedge rd_clk or negedge rd_rst) begin
        if (!rd_rst) begin
            lane_sel_q <= '0;
            valid_q    <= 1'b0;
        end else begin
            valid_q <= ram_re;
            if (ram_re) begin
                lane_sel_q <= item_ptr[`AFIFO_LANE_SEL_W-1:0];
            end
        end
    end

    // select 0 maps to lane 3, msb item first
    assign beat.valid = valid_q;
    assign beat.data  = ram_word.lanes[~lane_sel_q];

    // a beat only ever follows an accepted read
    a_valid_after_read: assert property (
        @(posedge rd_clk) disable iff (!rd_rst)
        beat.valid |-> $past(rd_en && !empty)
    ) else $error("valid without an accepted read");

endmodule

// ==== source/width_down_fifo.sv ====
`timescale 1ns/1ps

module width_down_fifo import afifo_pkg::*; (
    input  logic     wr_clk,
    input  logic     wr_rst,
    input  logic     wr_en,
    input  wr_word_u din,
    output logic     full,
    input  logic     rd_clk,
    input  logic     rd_rst,
    input  logic     rd_en,
    output logic     empty,
    output rd_beat_t beat
);

    word_ptr_t wr_ptr;
    word_ptr_t wr_ptr_gray;
    word_ptr_t wr_ptr_sync;    // write pointer seen in rd_clk
    word_ptr_t rd_addr;
    word_ptr_t rd_addr_gray;
    word_ptr_t rd_addr_sync;   // read address seen in wr_clk
    logic      ram_we;
    logic      ram_re;
    wr_word_u  ram_word;

    wr_ctrl u_wr_ctrl (
        .wr_clk       (wr_clk),
        .wr_rst       (wr_rst),
        .wr_en        (wr_en),
        .rd_addr_sync (rd_addr_sync),
        .wr_ptr       (wr_ptr),
        .wr_ptr_gray  (wr_ptr_gray),
        .ram_we       (ram_we),
        .full         (full)
    );

    gray_ptr_sync u_wr2rd_sync (
        .clk     (rd_clk),
        .rst     (rd_rst),
        .gray_in (wr_ptr_gray),
        .bin_out (wr_ptr_sync)
    );

    // each side resets its own synchronizer
    gray_ptr_sync u_rd2wr_sync (
        .clk     (wr_clk),
        .rst     (wr_rst),
        .gray_in (rd_addr_gray),
        .bin_out (rd_addr_sync)
    );

    word_ram u_word_ram (
        .wr_clk  (wr_clk),
        .we      (ram_we),
        .wr_addr (wr_ptr),
        .wr_data (din),
        .rd_clk  (rd_clk),
        .re      (ram_re),
        .rd_addr (rd_addr),
        .rd_data (ram_word)
    );

    rd_ctrl u_rd_ctrl (
        .rd_clk       (rd_clk),
        .rd_rst       (rd_rst),
        .rd_en        (rd_en),
        .wr_ptr_sync  (wr_ptr_sync),
        .ram_word     (ram_word),
        .rd_addr      (rd_addr),
        .rd_addr_gray (rd_addr_gray),
        .ram_re       (ram_re),
        .empty        (empty),
        .beat         (beat)
    );

endmodule

// ==== source/word_ram.sv ====
`timescale 1ns/1ps
`include "afifo_consts.svh"

module word_ram import afifo_pkg::*; (
    input  logic      wr_clk,
    input  logic      we,
    input  word_ptr_t wr_addr,
    input  wr_word_u  wr_data,
    input  logic      rd_clk,
    input  logic      re,
    input  word_ptr_t rd_addr,
    output wr_word_u  rd_data
);

    wr_word_u mem [0:`AFIFO_DEPTH-1];

    logic [`AFIFO_ADDR_W-1:0] wr_idx;
    logic [`AFIFO_ADDR_W-1:0] rd_idx;

    // wrap bit is flag logic only
    assign wr_idx = wr_addr[`AFIFO_ADDR_W-1:0];
    assign rd_idx = rd_addr[`AFIFO_ADDR_W-1:0];

    // write port, wr_clk domain
    always_ff @(posedge wr_clk) begin
        if (we) begin
            mem[wr_idx] <= wr_data;
        end
    end

    // read port holds its last word while re is low
    always_ff @(posedge rd_clk) begin
        if (re) begin
            rd_data <= mem[rd_idx];
        end
    end

endmodule

// ==== source/wr_ctrl.sv ====
`timescale 1ns/1ps
`include "afifo_consts.svh"

module wr_ctrl import afifo_pkg::*; (
    input  logic      wr_clk,
    input  logic      wr_rst,
    input  logic      wr_en,
    input  word_ptr_t rd_addr_sync,
    output word_ptr_t wr_ptr,
    output word_ptr_t wr_ptr_gray,
    output logic      ram_we,
    output logic      full
);

    word_ptr_t wr_ptr_next;

    // same slot, opposite lap
    assign full = (wr_ptr[`AFIFO_ADDR_W] != rd_addr_sync[`AFIFO_ADDR_W]) &&
                  (wr_ptr[`AFIFO_ADDR_W-1:0] == rd_addr_sync[`AFIFO_ADDR_W-1:0]);

    assign ram_we      = wr_en && !full;   // accepted write
    assign wr_ptr_next = wr_ptr + 1'b1;

    // gray copy is a flop so the crossing never sees a decode glitch
    always_ff @(posedge wr_clk or negedge wr_rst) begin
        if (!wr_rst) begin
            wr_ptr      <= '0;
            wr_ptr_gray <= '0;
        end else if (ram_we) begin
            wr_ptr      <= wr_ptr_next;
            wr_ptr_gray <= wr_ptr_next ^ (wr_ptr_next >> 1);
        end
    end

    // a full fifo keeps its write pointer parked
    a_no_adv_when_full: assert property (
        @(posedge wr_clk) disable iff (!wr_rst)
        full |=> $stable(wr_ptr)
    ) else $error("write pointer moved while full");

endmodule

// ==== tb/tb_width_down_fifo.sv ====
`timescale 1ns/1ps
`include "afifo_consts.svh"

module tb_width_down_fifo import afifo_pkg::*; ();

    // all four phases take around 2000 rd_clk cycles, so this leaves a wide margin
    localparam int TIMEOUT_CYCLES = 20000;
    localparam int RESET_CYCLES   = 10;

    logic     rd_clk;
    logic     wr_clk;
    logic     rd_rst = 1'b0;
    logic     wr_rst = 1'b0;
    logic     wr_en  = 1'b0;
    wr_word_u din    = '0;
    logic     full;
    logic     rd_en  = 1'b0;
    logic     empty;
    rd_beat_t beat;

    logic [`AFIFO_LANE_W-1:0] exp_q[$];   // expected items, oldest first
    int exp_count = 0;

    int          errors       = 0;
    int          phase        = 0;
    int          cycle_count  = 0;
    bit          wr_active    = 1'b0;
    bit          rd_active    = 1'b0;
    int          wr_density   = 0;   // percent of cycles with wr_en high
    int          rd_density   = 0;
    int          words_left   = 0;
    int          words_landed = 0;   // accepted writes already past their edge
    bit          wr_accept    = 1'b0;

    // read model, one beat in flight
    bit                       pend_valid = 1'b0;
    logic [`AFIFO_LANE_W-1:0] pend_data  = '0;
    bit                       exp_valid  = 1'b0;
    logic [`AFIFO_LANE_W-1:0] exp_data   = '0;
    bit                       beats_seen = 1'b0;

    initial begin
        rd_clk = 1'b0;
        forever #2 rd_clk = ~rd_clk;
    end

    initial begin
        wr_clk = 1'b0;
        forever #3 wr_clk = ~wr_clk;
    end

    width_down_fifo u_width_down_fifo (
        .wr_clk (wr_clk),
        .wr_rst (wr_rst),
        .wr_en  (wr_en),
        .din    (din),
        .full   (full),
        .rd_clk (rd_clk),
        .rd_rst (rd_rst),
        .rd_en  (rd_en),
        .empty  (empty),
        .beat   (beat)
    );

    task automatic flag_error(input string msg);
        errors++;
        $display("FAILED %0t: %s", $time, msg);
    endtask

    // write side stimulus and expected items
    always @(negedge wr_clk) begin
        if (wr_accept) begin
            words_landed++;   // stored at the rising edge just gone
        end
        wr_en = 1'b0;
        if (wr_rst && wr_active && words_left > 0) begin
            wr_en   = int'($urandom % 100) < wr_density;
            din.raw = $urandom;
        end
        // full only moves on a wr_clk rising edge, so the next edge sees this value
        wr_accept = wr_en && !full;
        if (wr_accept) begin
            for (int l = `AFIFO_LANES - 1; l >= 0; l--) begin
                exp_q.push_back(din.raw[l*`AFIFO_LANE_W +: `AFIFO_LANE_W]);   // msb lane first
            end
            exp_count += `AFIFO_LANES;
            words_left--;
        end
    end

    // read side stimulus
    always @(negedge rd_clk) begin
        // beat of the read taken at the edge just gone is due at the next edge
        exp_valid = pend_valid;
        if (pend_valid) begin
            exp_data   = pend_data;
            beats_seen = 1'b1;
        end
        rd_en = 1'b0;
        if (rd_rst && rd_active) begin
            rd_en = int'($urandom % 100) < rd_density;
        end
        pend_valid = rd_en && !empty;   // empty only moves on rd_clk rising edges
        if (pend_valid) begin
            a_item_expected: assert (exp_count > 0)
                else flag_error("a read was accepted with no item written");
            if (exp_q.size() > 0) begin
                pend_data = exp_q.pop_front();
                exp_count--;
            end
        end
    end

    a_reset_rd_side: assert property (@(posedge rd_clk) disable iff (!rd_rst)
        words_landed == 0 |-> empty && !beat.valid)
        else flag_error("empty low or valid high before any write");

    a_reset_wr_side: assert property (@(posedge wr_clk) disable iff (!wr_rst)
        words_landed == 0 |-> !full)
        else flag_error("full high before any write");

    a_valid_timing: assert property (@(posedge rd_clk) disable iff (!rd_rst)
        beat.valid == exp_valid)
        else flag_error("beat.valid does not follow the accepted reads");

    // lane order and word order in one check
    a_data_order: assert property (@(posedge rd_clk) disable iff (!rd_rst)
        beat.valid |-> beat.data == exp_data)
        else flag_error("beat.data differs from the expected item");

    a_data_holds: assert property (@(posedge rd_clk) disable iff (!rd_rst)
        !beat.valid && beats_seen |-> $stable(beat.data))
        else flag_error("beat.data changed while valid was low");

    // full rises with the last slot taken and not a word earlier
    a_full_at_depth: assert property (@(posedge wr_clk) disable iff (!wr_rst)
        phase == 1 |-> full == (words_landed == `AFIFO_DEPTH))
        else flag_error("full does not match the number of words written");

    // no reads in phase 1, nothing may free a slot
    a_full_holds: assert property (@(posedge wr_clk) disable iff (!wr_rst)
        phase == 1 && full |=> full)
        else flag_error("full dropped with no reads");

    a_empty_after_drain: assert property (@(posedge rd_clk) disable iff (!rd_rst)
        phase == 2 && exp_count == 0 |=> empty)
        else flag_error("empty low after the last item was read");

    a_no_beat_when_empty: assert property (@(posedge rd_clk) disable iff (!rd_rst)
        phase == 4 |-> empty && !beat.valid)
        else flag_error("reads on an empty fifo produced a beat");

    initial begin
        while (cycle_count < TIMEOUT_CYCLES) begin
            @(posedge rd_clk);
            cycle_count++;
        end
        $display("timeout: the run was still going after %0d rd_clk cycles", TIMEOUT_CYCLES);
        $display("errors: %0d", errors);
        $display("Test FAILED");
        $finish;
    end

    initial begin
        void'($urandom(32'h49cb));
        repeat (RESET_CYCLES) @(negedge rd_clk);
        rd_rst = 1'b1;
        wr_rst = 1'b1;
        repeat (5) @(posedge rd_clk);

        // writes only, then keep pulsing into a full fifo
        phase      = 1;
        wr_density = 70;
        words_left = 1000;
        wr_active  = 1'b1;
        wait (full);
        repeat (12) @(posedge wr_clk);
        wr_active = 1'b0;
        repeat (4) @(posedge rd_clk);

        // drain
        phase      = 2;
        rd_density = 60;
        rd_active  = 1'b1;
        wait (exp_count == 0 && empty);
        repeat (4) @(posedge rd_clk);
        rd_active = 1'b0;

        // mixed traffic
        phase      = 3;
        wr_density = 50;
        rd_density = 55;
        words_left = 200;
        wr_active  = 1'b1;
        rd_active  = 1'b1;
        wait (words_left == 0);
        wait (exp_count == 0 && empty);
        repeat (4) @(posedge rd_clk);
        wr_active = 1'b0;
        rd_active = 1'b0;

        // rd_en held high on an empty fifo
        @(posedge rd_clk);
        phase      = 4;
        rd_density = 100;
        rd_active  = 1'b1;
        repeat (40) @(posedge rd_clk);
        rd_active = 1'b0;
        repeat (4) @(posedge rd_clk);

        a_queue_drained: assert (exp_q.size() == 0)
            else flag_error("written items never came out of the fifo");

        $display("checks done, errors: %0d", errors);
        if (errors == 0) begin
            $display("Test OK");
        end else begin
            $display("Test FAILED");
        end
        $finish;
    end

endmodule
